// File: common/sd_tx_pkg.sv
// Frame types, bus width codes and beat counts shared by the SD data-line transmit framer
`default_nettype none

package sd_tx_pkg;

	////////////////////////////////////////
	// Data types

	// One stream word, also one frame word on its way to the lanes
	typedef logic [31:0] word_t;

	// Lane vector, bit k drives data line k
	typedef logic [7:0] lanes_t;

	typedef logic [1:0] bus_width_t;

	// Beats still to go in the word being sent
	typedef logic [4:0] beat_count_t;

	////////////////////////////////////////
	// Bus width codes

	localparam bus_width_t WIDTH_1W = 2'd0;
	localparam bus_width_t WIDTH_4W = 2'd1;
	localparam bus_width_t WIDTH_8W = 2'd2;

	////////////////////////////////////////
	// Beats per word

	localparam int BEATS_1W = 32;
	localparam int BEATS_4W = 8;
	localparam int BEATS_8W = 4;

	// 1-lane CRC word only carries 16 bits in its top half
	localparam int BEATS_1W_CRC = 16;

	// Lines rest high between frames
	localparam word_t IDLE_WORD = '1;

	// Packet sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_DATA,
		SEQ_CRC,
		SEQ_LAST
	} seq_state_t;

endpackage

`default_nettype wire

// File: common/sd_crc_pkg.sv
// CRC-16 constants and the single-bit CRC step used for the per-lane data CRCs
`default_nettype none

package sd_crc_pkg;

	localparam int NCRC = 16;

	typedef logic [NCRC-1:0] crc_t;

	// CCITT polynomial, x^16 + x^12 + x^5 + 1
	localparam crc_t CRC_POLYNOMIAL = 16'h1021;

	// Widest bus, one CRC per lane
	localparam int MAX_LANES = 8;

	// CRC words sent after the data, per width
	localparam int CRC_WORDS_4W = 2;
	localparam int CRC_WORDS_8W = 4;

	////////////////////////////////////////
	// Advance a CRC by one data bit

	function automatic crc_t crc_step(input crc_t prior, input logic din);
		crc_t shifted;
		shifted = {prior[NCRC-2:0], 1'b0};
		if (prior[NCRC-1] ^ din)
			return shifted ^ CRC_POLYNOMIAL;
		return shifted;
	endfunction

endpackage

`default_nettype wire

// File: common/frame_word_if.sv
// Word channel from the frame sequencer to the lane serializer, with the latched bus width
`default_nettype none

interface frame_word_if;

	logic                    word_valid;
	sd_tx_pkg::word_t        word;
	// Set on the half-filled CRC word of 1-lane mode
	logic                    crc_short;
	logic                    word_ready;
	sd_tx_pkg::bus_width_t   width;

	modport sequencer (
		output word_valid,
		output word,
		output crc_short,
		output width,
		input  word_ready
	);

	modport serializer (
		input  word_valid,
		input  word,
		input  crc_short,
		input  width,
		output word_ready
	);

endinterface

`default_nettype wire

// File: sd_tx_frame/lane_crc.sv
// Per-lane CRC-16 registers, advanced by accepted words and read back as interleaved CRC words
`default_nettype none

module lane_crc (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  sd_tx_pkg::bus_width_t i_width,
	input  logic                  i_clear,
	input  logic                  i_advance,
	input  logic                  i_shift,
	input  sd_tx_pkg::word_t      i_data,
	output sd_tx_pkg::word_t      o_crc_word
);

	sd_crc_pkg::crc_t crc_q [sd_crc_pkg::MAX_LANES];
	sd_crc_pkg::crc_t crc_next [sd_crc_pkg::MAX_LANES];
	int               lanes_n;
	// Bits of one word that fall on each lane
	int               beats_n;

	always_comb begin
		case (i_width)
		sd_tx_pkg::WIDTH_1W: begin
			lanes_n = 1;
			beats_n = sd_tx_pkg::BEATS_1W;
		end
		sd_tx_pkg::WIDTH_4W: begin
			lanes_n = 4;
			beats_n = sd_tx_pkg::BEATS_4W;
		end
		default: begin
			lanes_n = sd_crc_pkg::MAX_LANES;
			beats_n = sd_tx_pkg::BEATS_8W;
		end
		endcase
	end

	// Lane k sees word bit (32 - lanes*(beat+1) + k) on each beat, MSB first
	always_comb begin
		sd_crc_pkg::crc_t fill;
		for (int k = 0; k < sd_crc_pkg::MAX_LANES; k++) begin
			fill = i_clear ? '0 : crc_q[k];
			if (i_advance) begin
				for (int j = 0; j < $bits(sd_tx_pkg::word_t); j++) begin
					if (j < beats_n && k < lanes_n)
						fill = sd_crc_pkg::crc_step(fill,
							i_data[$bits(sd_tx_pkg::word_t) - lanes_n * (j + 1) + k]);
				end
			end else if (i_shift && !i_clear) begin
				// Move the next word's worth of bits up, ones behind
				for (int b = sd_crc_pkg::NCRC - 1; b >= 0; b--)
					fill[b] = (b >= beats_n) ? crc_q[k][b - beats_n] : 1'b1;
			end
			crc_next[k] = fill;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_reset)
			crc_q <= '{default: '0};
		else
			crc_q <= crc_next;
	end

	// Top CRC word in serializer order, unused beats left high
	always_comb begin
		o_crc_word = sd_tx_pkg::IDLE_WORD;
		for (int j = 0; j < sd_crc_pkg::NCRC; j++) begin
			for (int k = 0; k < sd_crc_pkg::MAX_LANES; k++) begin
				if (j < beats_n && k < lanes_n)
					o_crc_word[$bits(sd_tx_pkg::word_t) - lanes_n * (j + 1) + k] =
						crc_q[k][sd_crc_pkg::NCRC - 1 - j];
			end
		end
	end

endmodule

`default_nettype wire

// File: sd_tx_frame/lane_serializer.sv
// Turns frame words into lane beats, one per clock strobe, framed by start and stop beats
`default_nettype none

module lane_serializer (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_ckstb,
	input  logic              i_start,
	output logic              o_busy,
	output logic              o_tx_valid,
	output sd_tx_pkg::lanes_t o_tx_data,
	frame_word_if.serializer  word_if
);

	sd_tx_pkg::beat_count_t count;
	sd_tx_pkg::word_t       sreg;
	sd_tx_pkg::word_t       src;
	logic                   stop_pending;
	logic                   load;
	logic                   drain;

	// Top lane group of a word, unused lanes high
	function automatic sd_tx_pkg::lanes_t lane_group(input sd_tx_pkg::word_t w,
			input sd_tx_pkg::bus_width_t width);
		case (width)
		sd_tx_pkg::WIDTH_1W: return {7'h7f, w[31]};
		sd_tx_pkg::WIDTH_4W: return {4'hf, w[31:28]};
		default:             return w[31:24];
		endcase
	endfunction

	function automatic sd_tx_pkg::word_t next_sreg(input sd_tx_pkg::word_t w,
			input sd_tx_pkg::bus_width_t width);
		case (width)
		sd_tx_pkg::WIDTH_1W: return {w[30:0], 1'b1};
		sd_tx_pkg::WIDTH_4W: return {w[27:0], 4'hf};
		default:             return {w[23:0], 8'hff};
		endcase
	endfunction

	// Beats left after the first one of a freshly loaded word
	function automatic sd_tx_pkg::beat_count_t last_beat(input sd_tx_pkg::bus_width_t width,
			input logic crc_short);
		if (crc_short)
			return sd_tx_pkg::beat_count_t'(sd_tx_pkg::BEATS_1W_CRC - 1);
		case (width)
		sd_tx_pkg::WIDTH_1W: return sd_tx_pkg::beat_count_t'(sd_tx_pkg::BEATS_1W - 1);
		sd_tx_pkg::WIDTH_4W: return sd_tx_pkg::beat_count_t'(sd_tx_pkg::BEATS_4W - 1);
		default:             return sd_tx_pkg::beat_count_t'(sd_tx_pkg::BEATS_8W - 1);
		endcase
	endfunction

	assign word_if.word_ready = i_ckstb && (count == '0);
	assign load = word_if.word_valid && word_if.word_ready;
	assign drain = i_ckstb && (count != '0);
	assign src = load ? word_if.word : sreg;
	assign o_busy = o_tx_valid;

	always_ff @(posedge i_clk) begin
		if (!i_reset) begin
			o_tx_valid <= 1'b0;
			stop_pending <= 1'b0;
			count <= '0;
			o_tx_data <= '1;
		end else if (i_start) begin
			// Start beat: used lanes low, same as the group of an all-zero word
			o_tx_valid <= 1'b1;
			stop_pending <= 1'b1;
			o_tx_data <= lane_group('0, word_if.width);
		end else if (load) begin
			count <= last_beat(word_if.width, word_if.crc_short);
			o_tx_data <= lane_group(src, word_if.width);
		end else if (drain) begin
			count <= count - 1'b1;
			o_tx_data <= lane_group(src, word_if.width);
		end else if (i_ckstb) begin
			// Out of words, one stop beat then idle
			o_tx_valid <= stop_pending;
			stop_pending <= 1'b0;
			o_tx_data <= sd_tx_pkg::lanes_t'(sd_tx_pkg::IDLE_WORD);
		end
	end

	always_ff @(posedge i_clk) begin
		if (load || drain)
			sreg <= next_sreg(src, word_if.width);
	end

endmodule

`default_nettype wire

// File: sd_tx_frame/frame_sequencer.sv
// Packet state machine of the framer, feeds data words then CRC words to the lane serializer
`default_nettype none

module frame_sequencer (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_ckstb,
	input  sd_tx_pkg::bus_width_t i_cfg_width,
	input  logic                  i_s_valid,
	output logic                  o_s_ready,
	input  sd_tx_pkg::word_t      i_s_data,
	input  logic                  i_s_last,
	output logic                  o_crc_clear,
	output logic                  o_crc_advance,
	output logic                  o_crc_shift,
	input  sd_tx_pkg::word_t      i_crc_word,
	input  logic                  i_tx_busy,
	frame_word_if.sequencer       word_if
);

	sd_tx_pkg::seq_state_t state;
	sd_tx_pkg::bus_width_t cfg_width;
	sd_tx_pkg::word_t      word_q;
	logic                  valid_q;
	logic                  short_q;
	// CRC words still to load, minus one
	logic [1:0]            crc_left;
	logic                  start;
	logic                  accept;
	logic                  take;

	// First word is taken into the holding register with the start beat
	assign start = (state == sd_tx_pkg::SEQ_IDLE) && i_s_valid && i_ckstb && !i_tx_busy;
	assign take = valid_q && word_if.word_ready;
	assign o_s_ready = start || ((state == sd_tx_pkg::SEQ_DATA) && word_if.word_ready);
	assign accept = i_s_valid && o_s_ready;

	assign o_crc_clear = start;
	assign o_crc_advance = accept;
	assign o_crc_shift = (state == sd_tx_pkg::SEQ_CRC) && take;

	assign word_if.word_valid = valid_q;
	assign word_if.word = word_q;
	assign word_if.crc_short = short_q;
	assign word_if.width = cfg_width;

	////////////////////////////////////////
	// State machine

	always_ff @(posedge i_clk) begin
		if (!i_reset) begin
			state <= sd_tx_pkg::SEQ_IDLE;
			valid_q <= 1'b0;
			short_q <= 1'b0;
			cfg_width <= sd_tx_pkg::WIDTH_1W;
			crc_left <= '0;
		end else begin
			case (state)
			sd_tx_pkg::SEQ_IDLE: begin
				if (start) begin
					state <= i_s_last ? sd_tx_pkg::SEQ_CRC : sd_tx_pkg::SEQ_DATA;
					valid_q <= 1'b1;
				end else
					cfg_width <= i_cfg_width;
			end
			sd_tx_pkg::SEQ_DATA: begin
				if (accept && i_s_last)
					state <= sd_tx_pkg::SEQ_CRC;
			end
			sd_tx_pkg::SEQ_CRC: begin
				if (take) begin
					short_q <= (cfg_width == sd_tx_pkg::WIDTH_1W);
					if (crc_left == 2'd0)
						state <= sd_tx_pkg::SEQ_LAST;
					else
						crc_left <= crc_left - 2'd1;
				end
			end
			default: begin
				// Last CRC word drains, then wait out the stop beat
				if (take) begin
					valid_q <= 1'b0;
					short_q <= 1'b0;
				end
				if (!i_tx_busy)
					state <= sd_tx_pkg::SEQ_IDLE;
			end
			endcase

			if (state == sd_tx_pkg::SEQ_IDLE || state == sd_tx_pkg::SEQ_DATA) begin
				case (cfg_width)
				sd_tx_pkg::WIDTH_1W: crc_left <= 2'd0;
				sd_tx_pkg::WIDTH_4W: crc_left <= 2'(sd_crc_pkg::CRC_WORDS_4W - 1);
				default:             crc_left <= 2'(sd_crc_pkg::CRC_WORDS_8W - 1);
				endcase
			end
		end
	end

	// Holding register for the word on offer
	always_ff @(posedge i_clk) begin
		if (accept)
			word_q <= i_s_data;
		else if (o_crc_shift)
			word_q <= i_crc_word;
		else if (state == sd_tx_pkg::SEQ_LAST && take)
			word_q <= sd_tx_pkg::IDLE_WORD;
	end

endmodule

`default_nettype wire

// File: sd_tx_frame/sd_tx_frame.sv
// Top level of the SD data-line transmit framer, takes a word stream and drives framed lane beats
`default_nettype none

module sd_tx_frame (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_ckstb,
	input  sd_tx_pkg::bus_width_t i_cfg_width,
	input  logic                  i_s_valid,
	output logic                  o_s_ready,
	input  sd_tx_pkg::word_t      i_s_data,
	input  logic                  i_s_last,
	output logic                  o_tx_valid,
	output sd_tx_pkg::lanes_t     o_tx_data
);

	frame_word_if word_if ();

	logic             crc_clear;
	logic             crc_advance;
	logic             crc_shift;
	logic             tx_busy;
	sd_tx_pkg::word_t crc_word;

	frame_sequencer frame_sequencer_i (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_ckstb       (i_ckstb),
		.i_cfg_width   (i_cfg_width),
		.i_s_valid     (i_s_valid),
		.o_s_ready     (o_s_ready),
		.i_s_data      (i_s_data),
		.i_s_last      (i_s_last),
		.o_crc_clear   (crc_clear),
		.o_crc_advance (crc_advance),
		.o_crc_shift   (crc_shift),
		.i_crc_word    (crc_word),
		.i_tx_busy     (tx_busy),
		.word_if       (word_if.sequencer)
	);

	lane_crc lane_crc_i (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_width    (word_if.width),
		.i_clear    (crc_clear),
		.i_advance  (crc_advance),
		.i_shift    (crc_shift),
		.i_data     (i_s_data),
		.o_crc_word (crc_word)
	);

	// Block start also launches the start beat
	lane_serializer lane_serializer_i (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_ckstb    (i_ckstb),
		.i_start    (crc_clear),
		.o_busy     (tx_busy),
		.o_tx_valid (o_tx_valid),
		.o_tx_data  (o_tx_data),
		.word_if    (word_if.serializer)
	);

endmodule

`default_nettype wire

// File: bench/sd_tx_frame_assertions.sv
// Concurrent output checks for the framer, attached to the top level by the bind at the end
`default_nettype none

module sd_tx_frame_assertions (
	input logic                  i_clk,
	input logic                  i_reset,
	input logic                  i_ckstb,
	input sd_tx_pkg::bus_width_t i_width,
	input logic                  i_tx_valid,
	input sd_tx_pkg::lanes_t     i_tx_data
);

	timeunit 1ns;
	timeprecision 100ps;

	// Read by the testbench at the end of the run
	int fail_count = 0;

	// Lanes the latched width leaves unused
	function automatic sd_tx_pkg::lanes_t unused_lanes(input sd_tx_pkg::bus_width_t width);
		case (width)
		sd_tx_pkg::WIDTH_1W: return 8'hfe;
		sd_tx_pkg::WIDTH_4W: return 8'hf0;
		default:             return 8'h00;
		endcase
	endfunction

	idle_high: assert property (@(posedge i_clk) disable iff (!i_reset)
		!i_tx_valid |-> (i_tx_data == 8'hff))
	else begin
		fail_count++;
		$error("o_tx_data is not all ones while o_tx_valid is low");
	end

	unused_high: assert property (@(posedge i_clk) disable iff (!i_reset)
		(i_tx_data & unused_lanes(i_width)) == unused_lanes(i_width))
	else begin
		fail_count++;
		$error("An unused lane of o_tx_data went low");
	end

	// Beats only move on a strobe
	hold_between_strobes: assert property (@(posedge i_clk) disable iff (!i_reset)
		!$past(i_ckstb) |-> ($stable(i_tx_data) && $stable(i_tx_valid)))
	else begin
		fail_count++;
		$error("Outputs changed on a cycle without a strobe");
	end

endmodule

bind sd_tx_frame sd_tx_frame_assertions assertions_i (
	.i_clk      (i_clk),
	.i_reset    (i_reset),
	.i_ckstb    (i_ckstb),
	.i_width    (word_if.width),
	.i_tx_valid (o_tx_valid),
	.i_tx_data  (o_tx_data)
);

`default_nettype wire

// File: bench/sd_tx_frame_tb.sv
// Testbench for the SD data-line framer, sends fixed blocks in each width and checks every beat
`default_nettype none

module sd_tx_frame_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_BLOCKS = 8;

	logic                  i_clk;
	logic                  i_reset;
	logic                  i_ckstb;
	sd_tx_pkg::bus_width_t i_cfg_width;
	logic                  i_s_valid;
	logic                  o_s_ready;
	sd_tx_pkg::word_t      i_s_data;
	logic                  i_s_last;
	logic                  o_tx_valid;
	sd_tx_pkg::lanes_t     o_tx_data;

	// Blocks 0 to 2 stand alone, 3 to 7 run back to back
	sd_tx_pkg::bus_width_t block_width [N_BLOCKS] = '{
		sd_tx_pkg::WIDTH_1W, sd_tx_pkg::WIDTH_4W, sd_tx_pkg::WIDTH_8W, sd_tx_pkg::WIDTH_8W,
		sd_tx_pkg::WIDTH_1W, sd_tx_pkg::WIDTH_4W, sd_tx_pkg::WIDTH_8W, sd_tx_pkg::WIDTH_1W
	};
	int block_len [N_BLOCKS] = '{3, 4, 1, 3, 2, 3, 2, 1};

	sd_tx_pkg::word_t  block_words [$];
	sd_tx_pkg::lanes_t exp_beats [$];
	logic [31:0]       rng_state = 32'd41324;
	int                error_count = 0;
	int                accepted = 0;
	int                beats_seen = 0;
	int                words_framed = 0;
	int                cycle_count = 0;
	int                timeout_limit = 0;
	logic              strobe_seen = 1'b0;

	sd_tx_frame sd_tx_frame_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_ckstb     (i_ckstb),
		.i_cfg_width (i_cfg_width),
		.i_s_valid   (i_s_valid),
		.o_s_ready   (o_s_ready),
		.i_s_data    (i_s_data),
		.i_s_last    (i_s_last),
		.o_tx_valid  (o_tx_valid),
		.o_tx_data   (o_tx_data)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// Bus clock strobe, high on every third cycle
	initial begin : strobe_gen
		int phase;
		phase = 0;
		i_ckstb = 1'b0;
		forever begin
			@(negedge i_clk);
			i_ckstb = (phase == 2);
			phase = (phase + 1) % 3;
		end
	end

	////////////////////////////////////////
	// Reference model

	function automatic logic [31:0] xorshift32();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic int lanes_for(input sd_tx_pkg::bus_width_t width);
		case (width)
		sd_tx_pkg::WIDTH_1W: return 1;
		sd_tx_pkg::WIDTH_4W: return 4;
		default:             return 8;
		endcase
	endfunction

	// Start beat, data beats, 16 CRC beats, stop beat
	function automatic int frame_length(input sd_tx_pkg::bus_width_t width, input int words);
		return 1 + words * (32 / lanes_for(width)) + 16 + 1;
	endfunction

	function automatic sd_crc_pkg::crc_t crc16_bit(input sd_crc_pkg::crc_t crc, input logic din);
		sd_crc_pkg::crc_t shifted;
		shifted = crc << 1;
		return (crc[15] ^ din) ? (shifted ^ 16'h1021) : shifted;
	endfunction

	// Expected beats of the frame for block_words, appended to exp_beats
	function automatic void build_expected(input sd_tx_pkg::bus_width_t width);
		int                lanes;
		sd_crc_pkg::crc_t  crc [8];
		sd_tx_pkg::lanes_t beat;
		sd_tx_pkg::word_t  group;
		lanes = lanes_for(width);
		for (int k = 0; k < 8; k++)
			crc[k] = '0;
		beat = 8'hff;
		for (int k = 0; k < lanes; k++)
			beat[k] = 1'b0;
		exp_beats.push_back(beat);
		foreach (block_words[w]) begin
			for (int j = 0; j < 32 / lanes; j++) begin
				// MSB first, the top lane group lands on lanes 0 and up
				group = block_words[w] >> (32 - lanes * (j + 1));
				beat = 8'hff;
				for (int k = 0; k < lanes; k++) begin
					beat[k] = group[k];
					crc[k] = crc16_bit(crc[k], group[k]);
				end
				exp_beats.push_back(beat);
			end
		end
		for (int j = 0; j < 16; j++) begin
			beat = 8'hff;
			for (int k = 0; k < lanes; k++)
				beat[k] = crc[k][15 - j];
			exp_beats.push_back(beat);
		end
		exp_beats.push_back(8'hff);
	endfunction

	////////////////////////////////////////
	// Compare tasks

	task automatic check_lanes(input string name, input sd_tx_pkg::lanes_t got,
			input sd_tx_pkg::lanes_t exp);
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input sd_tx_pkg::beat_count_t got,
			input sd_tx_pkg::beat_count_t exp);
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// A beat is valid on the cycle after its strobe
	always @(posedge i_clk) begin
		if (!i_reset) begin
			strobe_seen <= 1'b0;
		end else begin
			if (strobe_seen && o_tx_valid) begin
				beats_seen++;
				if (exp_beats.size() == 0) begin
					error_count++;
					$display("Beat sent at %0t ns while no beat was expected", $time);
				end else begin
					check_lanes("o_tx_data", o_tx_data, exp_beats.pop_front());
				end
			end
			strobe_seen <= i_ckstb;
		end
	end

	always @(posedge i_clk) begin
		cycle_count <= cycle_count + 1;
		if (i_reset && i_s_valid && o_s_ready)
			accepted <= accepted + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			$display("Timeout after %0d cycles, the frames did not complete", timeout_limit);
			$display("Errors found");
			$finish;
		end
	end

	task automatic run_block(input sd_tx_pkg::bus_width_t width, input int len,
			input logic back_to_back);
		int sent;
		int beats_before;
		int frame_words;
		if (back_to_back) begin
			// Width change lands on the one idle cycle before the next strobe
			@(negedge i_clk);
			i_cfg_width = width;
			@(negedge i_clk);
		end else begin
			// Width is latched only while idle
			repeat (4) @(negedge i_clk);
			i_cfg_width = width;
			repeat (3) @(negedge i_clk);
		end
		block_words.delete();
		for (int i = 0; i < len; i++)
			block_words.push_back(xorshift32());
		build_expected(width);
		beats_before = beats_seen;
		sent = 0;
		i_s_valid = 1'b1;
		i_s_data = block_words[0];
		i_s_last = (len == 1);
		while (sent < len) begin
			@(posedge i_clk);
			if (o_s_ready) begin
				sent++;
				@(negedge i_clk);
				if (sent < len) begin
					i_s_data = block_words[sent];
					i_s_last = (sent == len - 1);
				end else begin
					i_s_valid = 1'b0;
					i_s_data = '0;
					i_s_last = 1'b0;
				end
			end
		end
		// Frame runs on through the CRC and the stop beat
		@(posedge i_clk);
		while (o_tx_valid)
			@(posedge i_clk);
		if (exp_beats.size() != 0) begin
			error_count++;
			$display("Frame ended at %0t ns with %0d beats missing", $time, exp_beats.size());
			exp_beats.delete();
		end
		// Data words on the lanes, less the start, CRC and stop beats
		frame_words = (beats_seen - beats_before - 18) / (32 / lanes_for(width));
		words_framed += frame_words;
		check_count("words framed", sd_tx_pkg::beat_count_t'(frame_words),
			sd_tx_pkg::beat_count_t'(len));
	endtask

	initial begin
		int total_beats;
		int errors_before;
		int assert_fails;
		i_reset = 1'b0;
		i_cfg_width = sd_tx_pkg::WIDTH_1W;
		i_s_valid = 1'b0;
		i_s_data = '0;
		i_s_last = 1'b0;
		total_beats = 0;
		errors_before = 0;
		for (int b = 0; b < N_BLOCKS; b++)
			total_beats += frame_length(block_width[b], block_len[b]);
		timeout_limit = 3 * (total_beats + 1) * 3;

		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_reset = 1'b1;
		@(negedge i_clk);
		check_bit("o_tx_valid", o_tx_valid, 1'b0);
		check_bit("o_s_ready", o_s_ready, 1'b0);
		check_lanes("o_tx_data", o_tx_data, 8'hff);
		$display("Test 1 reset state: %0d errors", error_count);

		for (int b = 0; b < N_BLOCKS; b++) begin
			if (b < 4)
				errors_before = error_count;
			run_block(block_width[b], block_len[b], b >= 3);
			if (b < 3)
				$display("Test %0d %0d-lane block of %0d words: %0d errors", b + 2,
					lanes_for(block_width[b]), block_len[b], error_count - errors_before);
		end
		$display("Test 5 back-to-back blocks in alternating widths: %0d errors",
			error_count - errors_before);

		// Words taken at the input against data words that reached the lanes
		errors_before = error_count;
		check_count("total words accepted", sd_tx_pkg::beat_count_t'(accepted),
			sd_tx_pkg::beat_count_t'(words_framed));
		$display("Test 6 accepted word count: %0d errors", error_count - errors_before);

		assert_fails = sd_tx_frame_i.assertions_i.fail_count;
		$display("Tests run 6, failed checks %0d, assertion failures %0d",
			error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: sd_tx_frame.f
common/sd_tx_pkg.sv
common/sd_crc_pkg.sv
common/frame_word_if.sv
sd_tx_frame/lane_crc.sv
sd_tx_frame/lane_serializer.sv
sd_tx_frame/frame_sequencer.sv
sd_tx_frame/sd_tx_frame.sv
bench/sd_tx_frame_assertions.sv
bench/sd_tx_frame_tb.sv
